// ==== rtl/rv_decode_pkg.sv ====
// shared RV32IM decode encodings, imported by every decode module
`default_nettype none

package rv_decode_pkg;

    // ****************************************
    // instruction fields
    // ****************************************
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t REG_X0 = 5'd0;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    localparam logic [2:0] F3_ADD    = 3'b000;
    localparam logic [2:0] F3_SLL    = 3'b001;
    localparam logic [2:0] F3_SLT    = 3'b010;
    localparam logic [2:0] F3_SLTU   = 3'b011;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_SRL    = 3'b101;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_MUL    = 3'b000;
    localparam logic [2:0] F3_MULH   = 3'b001;
    localparam logic [2:0] F3_MULHSU = 3'b010;
    localparam logic [2:0] F3_MULHU  = 3'b011;
    localparam logic [2:0] F3_DIV    = 3'b100;
    localparam logic [2:0] F3_DIVU   = 3'b101;
    localparam logic [2:0] F3_REM    = 3'b110;
    localparam logic [2:0] F3_REMU   = 3'b111;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;  // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // branch compares use 8 + funct3 and share codes with or/and
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_LT     = 5'd3,
        ALU_LTU    = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_MUL    = 5'd16,
        ALU_MULH   = 5'd17,
        ALU_MULHSU = 5'd18,
        ALU_MULHU  = 5'd19,
        ALU_DIV    = 5'd20,
        ALU_DIVU   = 5'd21,
        ALU_REM    = 5'd22,
        ALU_REMU   = 5'd23,
        ALU_NOP    = 5'd31
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_reg_t;

    typedef struct packed {
        logic [19:0] imm_hi;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } instr_upper_t;

    typedef union packed {
        instr_reg_t   regs;   // R/I/S/B layout
        instr_upper_t upper;  // U/J layout
    } instr_u;

    // ****************************************
    // bubble and fixed operands
    // ****************************************
    localparam alu_op_e BUBBLE_ALU_OP = ALU_ADD;
    localparam word_t   LUI_SHIFT     = 32'd12;
    localparam word_t   LINK_OFFSET   = 32'd4;  // return address step

endpackage

`default_nettype wire

// ==== rtl/alu_op_decoder.sv ====
// combinational ALU operation decode, feeds the decode stage register
`default_nettype none
`timescale 1ns/10ps

module alu_op_decoder import rv_decode_pkg::*; (
    input  instr_u  instr_i,
    output alu_op_e alu_op_o
);

    // funct3 table shared by OP and OP_IMM
    function automatic alu_op_e base_op(input logic [2:0] f3);
        case (f3)
            F3_ADD:  return ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_LT;
            F3_SLTU: return ALU_LTU;
            F3_XOR:  return ALU_XOR;
            F3_SRL:  return ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_op_e muldiv_op(input logic [2:0] f3);
        case (f3)
            F3_MUL:    return ALU_MUL;
            F3_MULH:   return ALU_MULH;
            F3_MULHSU: return ALU_MULHSU;
            F3_MULHU:  return ALU_MULHU;
            F3_DIV:    return ALU_DIV;
            F3_DIVU:   return ALU_DIVU;
            F3_REM:    return ALU_REM;
            default:   return ALU_REMU;
        endcase
    endfunction

    always_comb begin
        alu_op_o = ALU_NOP;
        case (instr_i.regs.opcode)
            OP: begin
                case (instr_i.regs.funct7)
                    F7_BASE:   alu_op_o = base_op(instr_i.regs.funct3);
                    F7_MULDIV: alu_op_o = muldiv_op(instr_i.regs.funct3);
                    F7_ALT: begin
                        if (instr_i.regs.funct3 == F3_ADD) begin
                            alu_op_o = ALU_SUB;
                        end else if (instr_i.regs.funct3 == F3_SRL) begin
                            alu_op_o = ALU_SRA;
                        end
                    end
                    default: alu_op_o = ALU_NOP;
                endcase
            end
            OP_IMM: begin
                alu_op_o = base_op(instr_i.regs.funct3);
                if (instr_i.regs.funct3 == F3_SRL && instr_i.regs.funct7 != F7_BASE) begin
                    alu_op_o = ALU_SRA;  // srai
                end
            end
            LUI:    alu_op_o = ALU_SLL;  // imm1 << 12
            AUIPC, JAL, JALR, LOAD, STORE: begin
                alu_op_o = ALU_ADD;
            end
            BRANCH: alu_op_o = alu_op_e'({2'b01, instr_i.regs.funct3});
            default: alu_op_o = ALU_NOP;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/operand_ctrl_decoder.sv ====
// combinational operand, jump and memory control decode with immediate assembly
`default_nettype none
`timescale 1ns/10ps

module operand_ctrl_decoder import rv_decode_pkg::*; (
    input  instr_u      instr_i,
    output logic        pc_sel_o,
    output logic [1:0]  rs_en_o,     // [0] rs1, [1] rs2
    output logic        wr_en_o,
    output logic [2:0]  jmp_ctrl_o,  // link reg, uncond, cond
    output logic [4:0]  mem_ctrl_o,  // funct3, write, use
    output logic [1:0]  imm_en_o,
    output word_t       imm0_o,
    output word_t       imm1_o
);

    logic [11:0] imm_i_raw;
    word_t       imm_i_sx;
    word_t       imm_s_sx;
    word_t       imm_b_sx;
    word_t       imm_j_sx;
    word_t       imm_u_sh;

    // ****************************************
    // immediate formats
    // ****************************************
    assign imm_i_raw = {instr_i.regs.funct7, instr_i.regs.rs2};
    assign imm_i_sx  = {{20{imm_i_raw[11]}}, imm_i_raw};
    assign imm_s_sx  = {{20{instr_i.regs.funct7[6]}}, instr_i.regs.funct7, instr_i.regs.rd};
    assign imm_b_sx  = {{19{instr_i.regs.funct7[6]}}, instr_i.regs.funct7[6],
                        instr_i.regs.rd[0], instr_i.regs.funct7[5:0],
                        instr_i.regs.rd[4:1], 1'b0};
    assign imm_j_sx  = {{11{instr_i.upper.imm_hi[19]}}, instr_i.upper.imm_hi[19],
                        instr_i.upper.imm_hi[7:0], instr_i.upper.imm_hi[8],
                        instr_i.upper.imm_hi[18:9], 1'b0};
    assign imm_u_sh  = {instr_i.upper.imm_hi, 12'b0};

    // ****************************************
    // per-opcode controls
    // ****************************************
    always_comb begin
        pc_sel_o   = 1'b0;
        rs_en_o    = 2'b00;
        wr_en_o    = 1'b0;
        jmp_ctrl_o = 3'b000;
        mem_ctrl_o = 5'b00000;
        imm_en_o   = 2'b00;
        imm0_o     = '0;
        imm1_o     = '0;
        case (instr_i.regs.opcode)
            OP: begin
                rs_en_o = 2'b11;
                wr_en_o = 1'b1;
            end
            OP_IMM: begin
                rs_en_o  = 2'b01;
                wr_en_o  = 1'b1;
                imm_en_o = 2'b01;
                imm0_o   = (instr_i.regs.funct3 == F3_SLTU) ? {20'b0, imm_i_raw} : imm_i_sx;
            end
            AUIPC: begin
                pc_sel_o = 1'b1;
                wr_en_o  = 1'b1;
                imm_en_o = 2'b01;
                imm0_o   = imm_u_sh;
            end
            LUI: begin
                wr_en_o  = 1'b1;
                imm_en_o = 2'b11;
                imm1_o   = {12'b0, instr_i.upper.imm_hi};  // shifted in the ALU
                imm0_o   = LUI_SHIFT;
            end
            JAL: begin
                pc_sel_o   = 1'b1;
                wr_en_o    = 1'b1;
                jmp_ctrl_o = 3'b010;
                imm_en_o   = 2'b01;
                imm1_o     = imm_j_sx;
                imm0_o     = LINK_OFFSET;
            end
            JALR: begin
                pc_sel_o   = 1'b1;
                wr_en_o    = 1'b1;
                jmp_ctrl_o = 3'b110;
                imm_en_o   = 2'b01;
                imm1_o     = imm_i_sx;
                imm0_o     = LINK_OFFSET;
            end
            BRANCH: begin
                rs_en_o    = 2'b11;
                jmp_ctrl_o = 3'b001;
                imm1_o     = imm_b_sx;  // target offset
            end
            LOAD: begin
                rs_en_o    = 2'b01;
                wr_en_o    = 1'b1;
                mem_ctrl_o = {instr_i.regs.funct3, 2'b01};
                imm_en_o   = 2'b01;
                imm0_o     = imm_i_sx;
            end
            STORE: begin
                rs_en_o    = 2'b11;
                mem_ctrl_o = {instr_i.regs.funct3, 2'b11};
                imm_en_o   = 2'b01;
                imm0_o     = imm_s_sx;
            end
            default: ;  // unknown opcode stays all zero
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage_reg.sv ====
// decode-to-execute pipeline register with stall hold and synchronous flush
`default_nettype none
`timescale 1ns/10ps

module decode_stage_reg import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic        stall_i,
    input  instr_u      instr_i,
    input  alu_op_e     alu_op_i,
    input  logic        pc_sel_i,
    input  logic [1:0]  rs_en_i,
    input  logic        wr_en_i,
    input  logic [2:0]  jmp_ctrl_i,
    input  logic [4:0]  mem_ctrl_i,
    input  logic [1:0]  imm_en_i,
    input  word_t       imm0_i,
    input  word_t       imm1_i,
    output reg_addr_t   rs1_o,
    output reg_addr_t   rs2_o,
    output reg_addr_t   rd_o,
    output alu_op_e     alu_op_o,
    output logic        pc_sel_o,
    output logic [1:0]  rs_en_o,
    output logic        wr_en_o,
    output logic [2:0]  jmp_ctrl_o,
    output logic [4:0]  mem_ctrl_o,
    output logic [1:0]  imm_en_o,
    output word_t       imm0_o,
    output word_t       imm1_o
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rs1_o      <= REG_X0;
            rs2_o      <= REG_X0;
            rd_o       <= REG_X0;
            alu_op_o   <= BUBBLE_ALU_OP;
            pc_sel_o   <= 1'b0;
            rs_en_o    <= 2'b00;
            wr_en_o    <= 1'b0;
            jmp_ctrl_o <= 3'b000;
            mem_ctrl_o <= 5'b00000;
            imm_en_o   <= 2'b00;
            imm0_o     <= '0;
            imm1_o     <= '0;
        end else if (flush_i || !stall_i) begin  // flush beats stall
            rs1_o      <= flush_i ? REG_X0 : instr_i.regs.rs1;
            rs2_o      <= flush_i ? REG_X0 : instr_i.regs.rs2;
            rd_o       <= flush_i ? REG_X0 : instr_i.regs.rd;
            alu_op_o   <= flush_i ? BUBBLE_ALU_OP : alu_op_i;
            pc_sel_o   <= !flush_i && pc_sel_i;
            rs_en_o    <= flush_i ? 2'b00 : rs_en_i;
            wr_en_o    <= !flush_i && wr_en_i;
            jmp_ctrl_o <= flush_i ? 3'b000 : jmp_ctrl_i;
            mem_ctrl_o <= flush_i ? 5'b00000 : mem_ctrl_i;
            imm_en_o   <= flush_i ? 2'b00 : imm_en_i;
            imm0_o     <= flush_i ? '0 : imm0_i;
            imm1_o     <= flush_i ? '0 : imm1_i;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_decoder_top.sv ====
// RV32IM decode stage top, one registered decode per accepted instruction
`default_nettype none
`timescale 1ns/10ps

module rv_decoder_top import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush_i,
    input  logic        stall_i,
    input  word_t       instr_i,
    output logic        pc_sel_o,
    output logic [1:0]  rs_en_o,
    output reg_addr_t   rs1_o,
    output reg_addr_t   rs2_o,
    output reg_addr_t   rd_o,
    output alu_op_e     alu_op_o,
    output logic        wr_en_o,
    output logic [2:0]  jmp_ctrl_o,
    output logic [4:0]  mem_ctrl_o,
    output logic [1:0]  imm_en_o,
    output word_t       imm0_o,
    output word_t       imm1_o
);

    alu_op_e     alu_op_d;
    logic        pc_sel_d;
    logic [1:0]  rs_en_d;
    logic        wr_en_d;
    logic [2:0]  jmp_ctrl_d;
    logic [4:0]  mem_ctrl_d;
    logic [1:0]  imm_en_d;
    word_t       imm0_d;
    word_t       imm1_d;

    alu_op_decoder u_alu_op_decoder (
        .instr_i  (instr_i),
        .alu_op_o (alu_op_d)
    );

    operand_ctrl_decoder u_operand_ctrl_decoder (
        .instr_i    (instr_i),
        .pc_sel_o   (pc_sel_d),
        .rs_en_o    (rs_en_d),
        .wr_en_o    (wr_en_d),
        .jmp_ctrl_o (jmp_ctrl_d),
        .mem_ctrl_o (mem_ctrl_d),
        .imm_en_o   (imm_en_d),
        .imm0_o     (imm0_d),
        .imm1_o     (imm1_d)
    );

    decode_stage_reg u_decode_stage_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (flush_i),
        .stall_i    (stall_i),
        .instr_i    (instr_i),     // register addresses
        .alu_op_i   (alu_op_d),
        .pc_sel_i   (pc_sel_d),
        .rs_en_i    (rs_en_d),
        .wr_en_i    (wr_en_d),
        .jmp_ctrl_i (jmp_ctrl_d),
        .mem_ctrl_i (mem_ctrl_d),
        .imm_en_i   (imm_en_d),
        .imm0_i     (imm0_d),
        .imm1_i     (imm1_d),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .rd_o       (rd_o),
        .alu_op_o   (alu_op_o),
        .pc_sel_o   (pc_sel_o),
        .rs_en_o    (rs_en_o),
        .wr_en_o    (wr_en_o),
        .jmp_ctrl_o (jmp_ctrl_o),
        .mem_ctrl_o (mem_ctrl_o),
        .imm_en_o   (imm_en_o),
        .imm0_o     (imm0_o),
        .imm1_o     (imm1_o)
    );

endmodule

`default_nettype wire

// ==== tests/rv_decoder_checker.sv ====
// bound assertions on reset, stall hold and flush of the decode stage outputs
`default_nettype none
`timescale 1ns/10ps

module rv_decoder_checker import rv_decode_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        flush_i,
    input logic        stall_i,
    input logic        pc_sel_o,
    input logic [1:0]  rs_en_o,
    input reg_addr_t   rs1_o,
    input reg_addr_t   rs2_o,
    input reg_addr_t   rd_o,
    input alu_op_e     alu_op_o,
    input logic        wr_en_o,
    input logic [2:0]  jmp_ctrl_o,
    input logic [4:0]  mem_ctrl_o,
    input logic [1:0]  imm_en_o,
    input word_t       imm0_o,
    input word_t       imm1_o
);

    logic [97:0] state_bits;   // every registered output
    logic        bubble;
    int unsigned fail_cnt = 0;

    assign state_bits = {pc_sel_o, rs_en_o, rs1_o, rs2_o, rd_o, alu_op_o, wr_en_o,
                         jmp_ctrl_o, mem_ctrl_o, imm_en_o, imm0_o, imm1_o};
    assign bubble = (alu_op_o == BUBBLE_ALU_OP) &&
                    ({pc_sel_o, rs_en_o, rs1_o, rs2_o, rd_o, wr_en_o, jmp_ctrl_o,
                      mem_ctrl_o, imm_en_o, imm0_o, imm1_o} == '0);

    // ****************************************
    // stage register properties
    // ****************************************
    reset_gives_bubble: assert property (@(posedge clk) !rst_n |=> bubble)
        else begin
            $error("outputs left the bubble state during reset");
            fail_cnt++;
        end

    stall_holds_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_i && !flush_i) |=> $stable(state_bits))
        else begin
            $error("outputs changed across a stalled edge");
            fail_cnt++;
        end

    flush_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> bubble)
        else begin
            $error("outputs not in the bubble state after a flush");
            fail_cnt++;
        end

endmodule

bind rv_decoder_top rv_decoder_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .stall_i    (stall_i),
    .pc_sel_o   (pc_sel_o),
    .rs_en_o    (rs_en_o),
    .rs1_o      (rs1_o),
    .rs2_o      (rs2_o),
    .rd_o       (rd_o),
    .alu_op_o   (alu_op_o),
    .wr_en_o    (wr_en_o),
    .jmp_ctrl_o (jmp_ctrl_o),
    .mem_ctrl_o (mem_ctrl_o),
    .imm_en_o   (imm_en_o),
    .imm0_o     (imm0_o),
    .imm1_o     (imm1_o)
);

`default_nettype wire

// ==== tests/tb_rv_decoder.sv ====
// testbench for the decode stage top, run as top module through project.f
`default_nettype none
`timescale 1ns/10ps

module tb_rv_decoder import rv_decode_pkg::*; ();

    localparam logic [31:0] SEED = 32'hca32_90c8;

    typedef struct packed {
        logic        pc_sel;
        logic [1:0]  rs_en;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [4:0]  alu_op;
        logic        wr_en;
        logic [2:0]  jmp;
        logic [4:0]  mem;
        logic [1:0]  imm_en;
        logic [31:0] imm0;
        logic [31:0] imm1;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        flush_i;
    logic        stall_i;
    logic [31:0] instr_i;
    logic        pc_sel_o;
    logic [1:0]  rs_en_o;
    logic [4:0]  rs1_o;
    logic [4:0]  rs2_o;
    logic [4:0]  rd_o;
    alu_op_e     alu_op_o;
    logic        wr_en_o;
    logic [2:0]  jmp_ctrl_o;
    logic [4:0]  mem_ctrl_o;
    logic [1:0]  imm_en_o;
    logic [31:0] imm0_o;
    logic [31:0] imm1_o;

    exp_t model;             // expected outputs after the last edge
    int   errors = 0;
    int   errors_mark = 0;
    int   checks = 0;
    int   tests = 0;
    logic timed_out = 1'b0;

    rv_decoder_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush_i    (flush_i),
        .stall_i    (stall_i),
        .instr_i    (instr_i),
        .pc_sel_o   (pc_sel_o),
        .rs_en_o    (rs_en_o),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .rd_o       (rd_o),
        .alu_op_o   (alu_op_o),
        .wr_en_o    (wr_en_o),
        .jmp_ctrl_o (jmp_ctrl_o),
        .mem_ctrl_o (mem_ctrl_o),
        .imm_en_o   (imm_en_o),
        .imm0_o     (imm0_o),
        .imm1_o     (imm1_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
    end

    // ****************************************
    // reference model
    // ****************************************
    function automatic logic [4:0] alu_ref_base(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_LT;
            3'd3:    return ALU_LTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic exp_t decode_ref(input logic [31:0] w);
        exp_t        e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        e      = '0;
        f3     = w[14:12];
        f7     = w[31:25];
        imm_i  = {{20{w[31]}}, w[31:20]};
        e.rs1  = w[19:15];
        e.rs2  = w[24:20];
        e.rd   = w[11:7];
        e.alu_op = ALU_NOP;
        case (w[6:0])
            OP: begin
                e.rs_en = 2'b11;
                e.wr_en = 1'b1;
                if (f7 == F7_BASE) e.alu_op = alu_ref_base(f3);
                else if (f7 == F7_MULDIV) e.alu_op = 5'd16 + {2'b00, f3};
                else if (f7 == F7_ALT && f3 == 3'd0) e.alu_op = ALU_SUB;
                else if (f7 == F7_ALT && f3 == 3'd5) e.alu_op = ALU_SRA;
            end
            OP_IMM: begin
                e.rs_en  = 2'b01;
                e.wr_en  = 1'b1;
                e.imm_en = 2'b01;
                e.alu_op = (f3 == 3'd5 && f7 != F7_BASE) ? ALU_SRA : alu_ref_base(f3);
                e.imm0   = (f3 == 3'd3) ? {20'b0, w[31:20]} : imm_i;  // sltiu
            end
            AUIPC: begin
                e = '{pc_sel: 1'b1, wr_en: 1'b1, imm_en: 2'b01, alu_op: ALU_ADD,
                      imm0: {w[31:12], 12'b0}, rs1: e.rs1, rs2: e.rs2, rd: e.rd, default: '0};
            end
            LUI: begin
                e.wr_en  = 1'b1;
                e.imm_en = 2'b11;
                e.alu_op = ALU_SLL;
                e.imm0   = 32'd12;
                e.imm1   = {12'b0, w[31:12]};
            end
            JAL, JALR: begin
                e.pc_sel = 1'b1;
                e.wr_en  = 1'b1;
                e.imm_en = 2'b01;
                e.alu_op = ALU_ADD;
                e.imm0   = 32'd4;
                e.jmp    = (w[6:0] == JAL) ? 3'b010 : 3'b110;
                e.imm1   = (w[6:0] == JAL) ?
                           {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0} : imm_i;
            end
            BRANCH: begin
                e.rs_en  = 2'b11;
                e.jmp    = 3'b001;
                e.alu_op = 5'd8 + {2'b00, f3};
                e.imm1   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            LOAD, STORE: begin
                e.rs_en  = (w[6:0] == LOAD) ? 2'b01 : 2'b11;
                e.wr_en  = (w[6:0] == LOAD);
                e.mem    = {f3, (w[6:0] == STORE), 1'b1};
                e.imm_en = 2'b01;
                e.alu_op = ALU_ADD;
                e.imm0   = (w[6:0] == LOAD) ? imm_i : {{20{w[31]}}, w[31:25], w[11:7]};
            end
            default: ;
        endcase
        return e;
    endfunction

    // ****************************************
    // stimulus and checks
    // ****************************************
    function automatic logic [31:0] random_instr(input logic [6:0] op);
        logic [31:0] r;
        r = $urandom();
        return {r[31:7], op};
    endfunction

    task automatic compare_field(string test, string field, logic [31:0] want,
                                 logic [31:0] got);
        checks++;
        assert (got == want) else begin
            $display("MISMATCH %s %s expected %h actual %h", test, field, want, got);
            errors++;
        end
    endtask

    task automatic verify_outputs(string test);
        compare_field(test, "pc_sel", 32'(model.pc_sel), 32'(pc_sel_o));
        compare_field(test, "rs_en", 32'(model.rs_en), 32'(rs_en_o));
        compare_field(test, "rs1", 32'(model.rs1), 32'(rs1_o));
        compare_field(test, "rs2", 32'(model.rs2), 32'(rs2_o));
        compare_field(test, "rd", 32'(model.rd), 32'(rd_o));
        compare_field(test, "alu_op", 32'(model.alu_op), 32'(alu_op_o));
        compare_field(test, "wr_en", 32'(model.wr_en), 32'(wr_en_o));
        compare_field(test, "jmp_ctrl", 32'(model.jmp), 32'(jmp_ctrl_o));
        compare_field(test, "mem_ctrl", 32'(model.mem), 32'(mem_ctrl_o));
        compare_field(test, "imm_en", 32'(model.imm_en), 32'(imm_en_o));
        compare_field(test, "imm0", model.imm0, imm0_o);
        compare_field(test, "imm1", model.imm1, imm1_o);
    endtask

    // one instruction in, checked at the negedge after the edge that samples it
    task automatic apply_instr(string test, logic [31:0] w, logic st, logic fl);
        @(posedge clk);
        instr_i <= w;
        stall_i <= st;
        flush_i <= fl;
        @(posedge clk);
        if (fl) model = '0;
        else if (!st) model = decode_ref(w);
        @(negedge clk);
        verify_outputs(test);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst_n && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("timeout: reset was not released within 20 cycles");
            timed_out = 1'b1;
        end
    endtask

    // flush to the bubble state, then report the test
    task automatic close_test(string test);
        int n;
        @(posedge clk);
        flush_i <= 1'b1;
        stall_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(alu_op_o == BUBBLE_ALU_OP && {pc_sel_o, rs_en_o, rs1_o, rs2_o, rd_o,
                   wr_en_o, jmp_ctrl_o, mem_ctrl_o, imm_en_o, imm0_o, imm1_o} == '0)
                   && n < 10);
        @(posedge clk);
        flush_i <= 1'b0;
        stall_i <= 1'b1;  // hold the bubble until the next test
        model = '0;
        if (n >= 10) begin
            $display("timeout: %s did not reach the bubble state after a flush", test);
            timed_out = 1'b1;
        end
        tests++;
        $display("test %s done, %0d errors", test, errors - errors_mark);
        errors_mark = errors;
    endtask

    task automatic reset_bubble();
        verify_outputs("reset_bubble");
        for (int k = 0; k < 3; k++) begin
            apply_instr("reset_bubble", random_instr(OP), 1'b1, 1'b0);
        end
        close_test("reset_bubble");
    endtask

    task automatic reg_reg_arith();
        logic [6:0]  f7_list [4];
        logic [31:0] w;
        f7_list = '{F7_BASE, F7_ALT, F7_MULDIV, 7'b0010000};
        for (int i = 0; i < 4; i++) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                w = random_instr(OP);
                w[31:25] = f7_list[i];
                w[14:12] = 3'(f3);
                apply_instr("reg_reg_arith", w, 1'b0, 1'b0);
            end
        end
        close_test("reg_reg_arith");
    endtask

    task automatic imm_arith();
        logic [31:0] w;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 3; k++) begin
                w = random_instr(OP_IMM);
                w[14:12] = 3'(f3);
                w[31] = (k == 1);                // negative immediate
                if (k == 2) w[31:25] = F7_ALT;
                apply_instr("imm_arith", w, 1'b0, 1'b0);
            end
        end
        close_test("imm_arith");
    endtask

    task automatic upper_jump_branch();
        logic [6:0]  ops [5];
        logic [31:0] w;
        ops = '{LUI, AUIPC, JAL, JALR, BRANCH};
        for (int i = 0; i < 5; i++) begin
            for (int k = 0; k < 8; k++) begin
                w = random_instr(ops[i]);
                w[14:12] = 3'(k);
                w[31] = k[0];
                apply_instr("upper_jump_branch", w, 1'b0, 1'b0);
            end
        end
        close_test("upper_jump_branch");
    endtask

    task automatic memory_access();
        logic [31:0] w;
        for (int k = 0; k < 16; k++) begin
            w = random_instr(k[3] ? STORE : LOAD);
            w[14:12] = 3'(k);
            w[31] = k[1];
            apply_instr("memory_access", w, 1'b0, 1'b0);
        end
        close_test("memory_access");
    endtask

    task automatic stall_flush_illegal();
        logic [6:0]  legal [9];
        logic [31:0] w;
        legal = '{OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE};
        apply_instr("stall_flush_illegal", random_instr(OP), 1'b0, 1'b0);
        for (int k = 0; k < 4; k++) begin
            w = $urandom();
            apply_instr("stall_flush_illegal", random_instr(legal[w % 9]), 1'b1, 1'b0);
        end
        apply_instr("stall_flush_illegal", random_instr(JAL), 1'b1, 1'b1);  // flush wins
        apply_instr("stall_flush_illegal", random_instr(LOAD), 1'b0, 1'b0);
        apply_instr("stall_flush_illegal", random_instr(STORE), 1'b0, 1'b1);
        for (int k = 0; k < 8; k++) begin
            w = $urandom();
            if (w[6:0] inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE}) begin
                w[6:0] = 7'b1111111;
            end
            apply_instr("stall_flush_illegal", w, 1'b0, 1'b0);
        end
        close_test("stall_flush_illegal");
    endtask

    initial begin
        void'($urandom(SEED));
        instr_i = '0;
        stall_i = 1'b1;  // keep the bubble after reset
        flush_i = 1'b0;
        model   = '0;
        wait_reset_release();
        if (!timed_out) reset_bubble();
        if (!timed_out) reg_reg_arith();
        if (!timed_out) imm_arith();
        if (!timed_out) upper_jump_branch();
        if (!timed_out) memory_access();
        if (!timed_out) stall_flush_illegal();
        errors += int'(dut0.u_checker.fail_cnt);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
rtl/rv_decode_pkg.sv
rtl/alu_op_decoder.sv
rtl/operand_ctrl_decoder.sv
rtl/decode_stage_reg.sv
rtl/rv_decoder_top.sv
tests/rv_decoder_checker.sv
tests/tb_rv_decoder.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f project.f --top-module tb_rv_decoder -o tb_rv_decoder

# the last command decides the exit status of the script
./obj_dir/tb_rv_decoder 2>&1 | tee /dev/stderr | grep -x "Test OK" > /dev/null
